// File: fusionPkg.sv
`default_nettype none

package fusionPkg;

  // data and weight word width
  localparam int dataWidth = 8;
  // operand width of one brick
  localparam int fieldWidth = 2;
  // fields per data or weight word
  localparam int fieldCount = dataWidth / fieldWidth;
  // one brick per data field and weight field pair
  localparam int brickCount = fieldCount * fieldCount;
  // signed result, covers -255*128 up to 255*127
  localparam int resultWidth = 17;
  // brick shift width, largest shift is 12
  localparam int shiftWidth = 4;

  // unsigned activation word
  typedef logic [dataWidth-1:0] data_t;
  // signed weight word
  typedef logic signed [dataWidth-1:0] weight_t;
  // signed result and partial products
  typedef logic signed [resultWidth-1:0] result_t;
  // left shift applied to one brick product
  typedef logic [shiftWidth-1:0] brickShift_t;
  // one bit per brick
  typedef logic [brickCount-1:0] brickMask_t;
  // one bit per weight field
  typedef logic [fieldCount-1:0] fieldMask_t;

  // precision mode, code 00 falls back to mode 2
  typedef enum logic [1:0] {
    modeTwo   = 2'b01,
    modeFour  = 2'b10,
    modeEight = 2'b11
  } precisionMode_t;

endpackage

`default_nettype wire

// File: fusionControl.sv
`timescale 1ns/10ps
`default_nettype none

module fusionControl import fusionPkg::*;
(
  input wire precisionMode_t mode,
  output brickMask_t brickEnable,
  output fieldMask_t fieldSigned,
  output brickShift_t brickShift [brickCount]
);

  // brick index is dataField * fieldCount + weightField
  always_comb
  begin
    int brick;
    brick = 0;
    brickEnable = '0;
    // which weight fields hold a sign bit
    case (mode)
      modeEight: fieldSigned = 4'b1000;
      modeFour:  fieldSigned = 4'b1010;
      // mode 2 and the unused code 00
      default:   fieldSigned = 4'b1111;
    endcase
    for (int i = 0; i < fieldCount; i++)
    begin
      for (int j = 0; j < fieldCount; j++)
      begin
        brick = i * fieldCount + j;
        case (mode)
          modeEight:
          begin
            // full 8x8 grid, weight 4^(i+j)
            brickEnable[brick] = 1'b1;
            brickShift[brick] = brickShift_t'(fieldWidth * (i + j));
          end
          modeFour:
          begin
            // only pairs inside the same nibble lane
            brickEnable[brick] = (i / 2) == (j / 2);
            brickShift[brick] = brickShift_t'(fieldWidth * ((i % 2) + (j % 2)));
          end
          default:
          begin
            // diagonal only, each lane is a plain 2x2 product
            brickEnable[brick] = (i == j);
            brickShift[brick] = '0;
          end
        endcase
      end
    end
    // each mode fuses the whole grid, two 4x4 lanes or four 2x2 lanes
    assert ($countones(brickEnable) inside {4, 8, 16})
      else $error("fusionControl: bad enable count %0d", $countones(brickEnable));
  end

endmodule

`default_nettype wire

// File: brickArray.sv
`timescale 1ns/10ps
`default_nettype none

module brickArray import fusionPkg::*;
(
  input wire data_t d,
  input wire weight_t w,
  input wire brickMask_t brickEnable,
  input wire fieldMask_t fieldSigned,
  input wire brickShift_t brickShift [brickCount],
  output result_t partial [brickCount]
);

  // one 2x2 brick per data field and weight field pair
  for (genvar b = 0; b < brickCount; b++)
  begin : genBrick
    // data field index, selects the column of the grid
    localparam int dataField = b / fieldCount;
    // weight field index, selects the row
    localparam int weightField = b % fieldCount;

    logic [fieldWidth-1:0] dBits;
    logic [fieldWidth-1:0] wBits;
    // operands one bit wider so both fit a signed multiply
    logic signed [fieldWidth:0] dOperand;
    logic signed [fieldWidth:0] wOperand;
    // brick product, -6 up to 9
    logic signed [2*fieldWidth:0] product;
    // product sign-extended to the result width
    result_t extended;

    assign dBits = d[dataField*fieldWidth +: fieldWidth];
    assign wBits = w[weightField*fieldWidth +: fieldWidth];

    // data is always unsigned
    assign dOperand = {1'b0, dBits};
    // only the top field of each weight lane carries the sign
    assign wOperand = {fieldSigned[weightField] & wBits[fieldWidth-1], wBits};

    assign product = dOperand * wOperand;
    assign extended = result_t'(product);

    always_comb
    begin
      // align to the brick's place in the fused word
      if (brickEnable[b])
      begin
        partial[b] = extended << brickShift[b];
      end
      else
      begin
        partial[b] = '0;
      end
      // a masked brick must not leak into another lane's sum
      assert (brickEnable[b] || partial[b] == '0)
        else $error("brickArray: disabled brick %0d is nonzero", b);
    end
  end

endmodule

`default_nettype wire

// File: csaTree.sv
`timescale 1ns/10ps
`default_nettype none

module csaTree import fusionPkg::*;
(
  input wire logic clk,
  input wire logic rstN,
  input wire result_t partial [brickCount],
  output result_t sum,
  output result_t carry
);

  // words left after a number of 3:2 levels
  function automatic int levelSize(input int level);
    int count;
    count = brickCount;
    for (int l = 0; l < level; l++)
    begin
      count = 2 * (count / 3) + count % 3;
    end
    return count;
  endfunction

  // levels needed to get down to two words
  function automatic int treeDepth();
    int depth;
    depth = 0;
    while (levelSize(depth) > 2)
    begin
      depth++;
    end
    return depth;
  endfunction

  // 16 -> 11 -> 8 -> 6 -> 4 -> 3 -> 2
  localparam int levelNum = treeDepth();

  // row l holds the words entering level l
  result_t stage [levelNum+1][brickCount];

  assign stage[0] = partial;

  for (genvar l = 0; l < levelNum; l++)
  begin : genLevel
    localparam int inCount = levelSize(l);
    localparam int outCount = levelSize(l + 1);
    localparam int groupCount = inCount / 3;

    // full adders per bit, carry word moves up one place
    for (genvar g = 0; g < groupCount; g++)
    begin : genCsa
      assign stage[l+1][2*g] = stage[l][3*g] ^ stage[l][3*g+1] ^ stage[l][3*g+2];
      // modulo wrap at the result width, the top carry drops out
      assign stage[l+1][2*g+1] = ((stage[l][3*g] & stage[l][3*g+1])
                                | (stage[l][3*g] & stage[l][3*g+2])
                                | (stage[l][3*g+1] & stage[l][3*g+2])) << 1;
    end

    // leftover words go straight to the next level
    for (genvar g = 0; g < inCount % 3; g++)
    begin : genPass
      assign stage[l+1][2*groupCount+g] = stage[l][3*groupCount+g];
    end

    // unused slots of the row
    for (genvar g = outCount; g < brickCount; g++)
    begin : genIdle
      assign stage[l+1][g] = '0;
    end
  end

  // pipeline stage one
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      sum <= '0;
      carry <= '0;
    end
    else
    begin
      sum <= stage[levelNum][0];
      carry <= stage[levelNum][1];
    end
  end

endmodule

`default_nettype wire

// File: lookaheadAdder.sv
`timescale 1ns/10ps
`default_nettype none

module lookaheadAdder import fusionPkg::*;
(
  input wire logic clk,
  input wire logic rstN,
  input wire result_t sum,
  input wire result_t carry,
  output result_t result
);

  localparam int groupWidth = 4;
  // 17 bits give five groups, the last one mostly padding
  localparam int groupCount = (resultWidth + groupWidth - 1) / groupWidth;
  localparam int paddedWidth = groupCount * groupWidth;

  logic [paddedWidth-1:0] gen;
  logic [paddedWidth-1:0] prop;
  // carry into each bit
  logic [paddedWidth-1:0] bitCarry;
  result_t total;

  // lookahead carries of one group, bit 0 is the group carry-in
  function automatic logic [groupWidth:0] groupCarries(
    input logic [groupWidth-1:0] g,
    input logic [groupWidth-1:0] p,
    input logic cin
  );
    logic [groupWidth:0] c;
    c[0] = cin;
    c[1] = g[0] | (p[0] & cin);
    c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
    c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0])
         | (&p & cin);
    return c;
  endfunction

  always_comb
  begin
    logic groupIn;
    logic [groupWidth:0] groupOut;
    // padding bits stay zero
    gen = '0;
    prop = '0;
    gen[resultWidth-1:0] = sum & carry;
    prop[resultWidth-1:0] = sum ^ carry;
    // carry-in of zero, groups ripple into each other
    groupIn = 1'b0;
    for (int n = 0; n < groupCount; n++)
    begin
      groupOut = groupCarries(gen[n*groupWidth +: groupWidth],
                              prop[n*groupWidth +: groupWidth], groupIn);
      bitCarry[n*groupWidth +: groupWidth] = groupOut[groupWidth-1:0];
      groupIn = groupOut[groupWidth];
    end
  end

  assign total = prop[resultWidth-1:0] ^ bitCarry[resultWidth-1:0];

  // pipeline stage two
  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      result <= '0;
    end
    else
    begin
      result <= total;
    end
  end

  // both pipeline stages come out of reset clean
  assert property (@(posedge clk) disable iff (!rstN) !$isunknown(result))
    else $error("lookaheadAdder: result is unknown");

endmodule

`default_nettype wire

// File: fusionUnit.sv
`timescale 1ns/10ps
`default_nettype none

module fusionUnit import fusionPkg::*;
(
  input wire logic clk,
  input wire logic rstN,
  input wire data_t d,
  input wire weight_t w,
  input wire precisionMode_t mode,
  output result_t result
);

  // fusion pattern from the mode decoder
  brickMask_t brickEnable;
  fieldMask_t fieldSigned;
  brickShift_t brickShift [brickCount];

  // aligned brick products
  result_t partial [brickCount];

  // carry-save pair between the two pipeline stages
  result_t sum;
  result_t carry;

  fusionControl control
  (
    .mode        (mode),
    .brickEnable (brickEnable),
    .fieldSigned (fieldSigned),
    .brickShift  (brickShift)
  );

  brickArray bricks
  (
    .d           (d),
    .w           (w),
    .brickEnable (brickEnable),
    .fieldSigned (fieldSigned),
    .brickShift  (brickShift),
    .partial     (partial)
  );

  // stage one, registered sum and carry
  csaTree tree
  (
    .clk     (clk),
    .rstN    (rstN),
    .partial (partial),
    .sum     (sum),
    .carry   (carry)
  );

  // stage two, registered result
  lookaheadAdder adder
  (
    .clk    (clk),
    .rstN   (rstN),
    .sum    (sum),
    .carry  (carry),
    .result (result)
  );

endmodule

`default_nettype wire

// File: tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock
(
  output logic clk,
  output logic rstN
);

  // 4 ns period
  localparam int halfPeriod = 2;
  localparam int resetCycles = 8;

  initial
  begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  // reset held low for the first eight rising edges
  initial
  begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tbFusionUnit.sv
`timescale 1ns/10ps
`default_nettype none

module tbFusionUnit import fusionPkg::*;
();

  localparam int resetTimeout = 50;
  localparam int randomCount = 40;
  localparam int streamCount = 200;

  logic clk;
  logic rstN;
  data_t d;
  weight_t w;
  precisionMode_t mode;
  result_t result;

  int errors;

  // expected results still in the pipeline, oldest first
  result_t expQ [$];
  string nameQ [$];
  bit validQ [$];

  tbClock clock
  (
    .clk  (clk),
    .rstN (rstN)
  );

  fusionUnit DUT
  (
    .clk    (clk),
    .rstN   (rstN),
    .d      (d),
    .w      (w),
    .mode   (mode),
    .result (result)
  );

  // two's complement value of a weight field
  function automatic int signedField(input int bits, input int width);
    if (bits >= (1 << (width - 1)))
      return bits - (1 << width);
    return bits;
  endfunction

  // sum of lane products, lanes are 8, 4 or 2 bits wide
  function automatic result_t refResult(input data_t dIn, input weight_t wIn,
                                        input logic [1:0] code);
    int acc;
    int width;
    int dv;
    int wv;
    int dField;
    int wField;
    acc = 0;
    dv = {24'b0, dIn};
    wv = {24'b0, wIn};
    case (code)
      2'b11: width = 8;
      2'b10: width = 4;
      // mode 2, code 00 falls back to it
      default: width = 2;
    endcase
    for (int n = 0; n < 8 / width; n++)
    begin
      dField = (dv >> (n * width)) % (1 << width);
      wField = (wv >> (n * width)) % (1 << width);
      // data unsigned, weight signed
      acc += dField * signedField(wField, width);
    end
    return result_t'(acc);
  endfunction

  task automatic reportMismatch(input string name, input result_t expected,
                                input result_t actual);
    $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
    errors++;
  endtask

  // apply one operand set and check the result of the set two edges back
  task automatic stepCycle(input data_t dIn, input weight_t wIn, input logic [1:0] code,
                           input bit check, input string name);
    result_t expected;
    string expName;
    bit expValid;
    @(posedge clk);
    d <= dIn;
    w <= wIn;
    mode <= precisionMode_t'(code);
    expQ.push_back(refResult(dIn, wIn, code));
    nameQ.push_back(name);
    validQ.push_back(check);
    // result is stable half a cycle after the edge
    @(negedge clk);
    if (expQ.size() > 2)
    begin
      expected = expQ.pop_front();
      expName = nameQ.pop_front();
      expValid = validQ.pop_front();
      if (expValid)
      begin
        assert (result == expected)
          else reportMismatch(expName, expected, result);
      end
    end
  endtask

  // two idle cycles push the last real results out
  task automatic drainPipe();
    stepCycle('0, '0, 2'b01, 1'b0, "drain");
    stepCycle('0, '0, 2'b01, 1'b0, "drain");
  endtask

  task automatic testReset();
    int waited;
    waited = 0;
    // result held at zero while reset is low
    while (rstN !== 1'b1 && waited <= resetTimeout)
    begin
      @(negedge clk);
      waited++;
      assert (result == '0)
        else reportMismatch("reset", '0, result);
    end
    if (rstN !== 1'b1)
    begin
      $display("reset was not released within %0d cycles", resetTimeout);
      errors++;
    end
    // and still zero one cycle after release
    @(negedge clk);
    assert (result == '0)
      else reportMismatch("resetRelease", '0, result);
  endtask

  task automatic testModeEight();
    // extremes of the signed product range
    stepCycle(8'd255, -8'sd128, 2'b11, 1'b1, "modeEightMin");
    stepCycle(8'd255, 8'sd127, 2'b11, 1'b1, "modeEightMax");
    stepCycle(8'd0, weight_t'($urandom()), 2'b11, 1'b1, "modeEightZeroData");
    stepCycle(data_t'($urandom()), -8'sd1, 2'b11, 1'b1, "modeEightMinusOne");
    stepCycle(8'd255, -8'sd1, 2'b11, 1'b1, "modeEightFullMinusOne");
    stepCycle(8'd0, -8'sd128, 2'b11, 1'b1, "modeEightZeroMin");
    for (int n = 0; n < 8; n++)
    begin
      stepCycle(data_t'($urandom()), weight_t'($urandom()), 2'b11, 1'b1, "modeEightRandom");
    end
    drainPipe();
  endtask

  task automatic testModeFour();
    // nibble corners first, then random words
    stepCycle(8'hff, 8'h88, 2'b10, 1'b1, "modeFourMin");
    stepCycle(8'hff, 8'h77, 2'b10, 1'b1, "modeFourMax");
    for (int n = 0; n < randomCount; n++)
    begin
      stepCycle(data_t'($urandom()), weight_t'($urandom()), 2'b10, 1'b1, "modeFour");
    end
    drainPipe();
  endtask

  task automatic testModeTwo();
    stepCycle(8'hff, 8'haa, 2'b01, 1'b1, "modeTwoMin");
    stepCycle(8'hff, 8'h55, 2'b00, 1'b1, "modeTwoDefaultMax");
    // alternate between code 01 and the unused code 00
    for (int n = 0; n < randomCount; n++)
    begin
      stepCycle(data_t'($urandom()), weight_t'($urandom()), (n % 2 == 0) ? 2'b01 : 2'b00,
                1'b1, "modeTwo");
    end
    drainPipe();
  endtask

  task automatic testBackToBack();
    logic [1:0] code;
    // new operands and mode every cycle, two in flight
    for (int n = 0; n < streamCount; n++)
    begin
      code = 2'($urandom_range(3, 0));
      stepCycle(data_t'($urandom()), weight_t'($urandom()), code, 1'b1, "backToBack");
    end
    drainPipe();
  endtask

  initial
  begin
    // operands held nonzero through reset so every stage must clear itself
    d = 8'hff;
    w = 8'h80;
    mode = modeEight;
    errors = 0;
    void'($urandom(32'he33ad481));
    testReset();
    testModeEight();
    testModeFour();
    testModeTwo();
    testBackToBack();
    $display("errors: %0d", errors);
    if (errors == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
fusionPkg.sv
fusionControl.sv
brickArray.sv
csaTree.sv
lookaheadAdder.sv
fusionUnit.sv
tbClock.sv
tbFusionUnit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tbFusionUnit -o simFusion
./obj_dir/simFusion > sim.log
cat sim.log
if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
